// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       := cam_diag_tb
FILE_LIST := src.f
BUILD_DIR := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/cam_diag_pkg.sv
// Camera diagnostic definitions
`default_nettype none

package cam_diag_pkg;

    // ******************************************************************
    // Widths and timing.
    // ******************************************************************
    localparam int line_cnt_w          = 10;
    localparam int cnt16_w             = 16;
    localparam int num_pages           = 5;
    localparam int page_idx_w          = $clog2(num_pages);
    localparam int pager_interval_clks = 600;   // Raised for a board build.
    localparam int pager_cnt_w         = $clog2(pager_interval_clks);
    localparam int i2c_clks_per_half   = 4;
    localparam int i2c_half_w          = $clog2(i2c_clks_per_half);
    localparam logic [6:0] logger_i2c_addr = 7'h5D;
    localparam int vsync_sync_stages   = 3;
    localparam int reset_release_clks  = 15;
    localparam int reset_cnt_w         = $clog2(reset_release_clks);

    // Logger states.
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    // ******************************************************************
    // Types.
    // ******************************************************************
    typedef struct packed {
        logic [12:0] reserved;
        logic        field_parity;
        logic        counts_equal;
        logic        frame_miss;
    } status_flags_t;

    // Page 4 reads the word as flags, every other page as a count.
    typedef union packed {
        logic [cnt16_w-1:0] raw;
        status_flags_t      flags;
    } diag_word_u;

    typedef struct packed {
        logic [7:0] page;
        diag_word_u value;
    } diag_sample_t;

    typedef struct packed {
        logic [cnt16_w-1:0] in_sof_cnt;
        logic [cnt16_w-1:0] out_vsync_cnt;
        logic               frame_miss;
    } sync_counts_t;

endpackage

`default_nettype wire

// File: hdl/cam_diag_top.sv
// Camera diagnostic top level
`default_nettype none

module cam_diag_top import cam_diag_pkg::*; (
    input  logic cam1_pclk,
    input  logic cam_resetn,
    input  logic line_valid,
    input  logic field_toggle,
    input  logic vsync_toggle,
    input  logic sda_in,
    output logic scl,
    output logic sda_drive_low
);

    logic                  rst_n;
    logic [line_cnt_w-1:0] lines_last;
    sync_counts_t          counts;
    logic                  field_parity;
    logic                  new_sample;
    diag_sample_t          sample;
    logic                  busy;

    reset_sync i_reset_sync (
        .cam1_pclk  (cam1_pclk),
        .cam_resetn (cam_resetn),
        .rst_n      (rst_n)
    );

    field_line_counter i_line_cnt (
        .cam1_pclk    (cam1_pclk),
        .rst_n        (rst_n),
        .line_valid   (line_valid),
        .field_toggle (field_toggle),
        .lines_last   (lines_last)
    );

    frame_sync_monitor i_sync_mon (
        .cam1_pclk    (cam1_pclk),
        .rst_n        (rst_n),
        .field_toggle (field_toggle),
        .vsync_toggle (vsync_toggle),
        .counts       (counts),
        .field_parity (field_parity)
    );

    diag_pager i_pager (
        .cam1_pclk    (cam1_pclk),
        .rst_n        (rst_n),
        .busy         (busy),
        .lines_last   (lines_last),
        .counts       (counts),
        .field_parity (field_parity),
        .new_sample   (new_sample),
        .sample       (sample)
    );

    i2c_frame_logger i_logger (
        .cam1_pclk     (cam1_pclk),
        .rst_n         (rst_n),
        .new_sample    (new_sample),
        .sample        (sample),
        .sda_in        (sda_in),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .busy          (busy)
    );

endmodule

`default_nettype wire

// File: hdl/diag_pager.sv
// Diagnostic page sequencer
`default_nettype none

module diag_pager import cam_diag_pkg::*; (
    input  logic                  cam1_pclk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic [line_cnt_w-1:0] lines_last,
    input  sync_counts_t          counts,
    input  logic                  field_parity,
    output logic                  new_sample,
    output diag_sample_t          sample
);

    logic [pager_cnt_w-1:0] interval_cnt;
    logic                   interval_fire;
    logic                   pending;     // Interval expired during a frame.
    logic [page_idx_w-1:0]  page_idx;
    logic                   offer;
    diag_word_u             page_word;

    assign interval_fire = (interval_cnt == pager_cnt_w'(pager_interval_clks - 1));

    // The logger raises busy one cycle after new_sample, so the pulse cycle blocks too.
    assign offer = (interval_fire || pending) && !busy && !new_sample;

    always_comb begin
        page_word = '0;
        case (page_idx)
            page_idx_w'(0): page_word.raw = cnt16_w'(lines_last);
            page_idx_w'(1): page_word.raw = counts.in_sof_cnt;
            page_idx_w'(2): page_word.raw = counts.out_vsync_cnt;
            page_idx_w'(3): page_word.raw = counts.in_sof_cnt - counts.out_vsync_cnt;
            default: begin
                page_word.flags.field_parity = field_parity;
                page_word.flags.counts_equal = (counts.in_sof_cnt == counts.out_vsync_cnt);
                page_word.flags.frame_miss   = counts.frame_miss;
            end
        endcase
    end

    always_ff @(posedge cam1_pclk or negedge rst_n) begin
        if (!rst_n) begin
            interval_cnt <= '0;
            pending      <= 1'b0;
            page_idx     <= '0;
            new_sample   <= 1'b0;
        end else begin
            new_sample <= offer;

            if (interval_fire) begin
                interval_cnt <= '0;
            end else begin
                interval_cnt <= interval_cnt + 1'b1;
            end

            if (offer) begin
                pending  <= 1'b0;
                page_idx <= (page_idx == page_idx_w'(num_pages - 1)) ? '0 : page_idx + 1'b1;
            end else if (interval_fire) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge cam1_pclk) begin
        if (offer) begin
            sample.page  <= 8'(page_idx);
            sample.value <= page_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/field_line_counter.sv
// Lines per field counter
`default_nettype none

module field_line_counter import cam_diag_pkg::*; (
    input  logic                  cam1_pclk,
    input  logic                  rst_n,
    input  logic                  line_valid,
    input  logic                  field_toggle,
    output logic [line_cnt_w-1:0] lines_last
);

    logic                  line_d;
    logic                  field_d;
    logic                  line_rise;
    logic                  field_change;
    logic [line_cnt_w-1:0] line_cnt;

    assign line_rise    = line_valid & ~line_d;
    assign field_change = field_toggle ^ field_d;

    always_ff @(posedge cam1_pclk or negedge rst_n) begin
        if (!rst_n) begin
            line_d     <= 1'b0;
            field_d    <= 1'b0;
            line_cnt   <= '0;
            lines_last <= '0;
        end else begin
            line_d  <= line_valid;
            field_d <= field_toggle;

            if (field_change) begin
                lines_last <= line_cnt;
                // A line starting on the boundary belongs to the new field.
                line_cnt   <= line_cnt_w'(line_rise);
            end else if (line_rise) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_sync_monitor.sv
// Field start and vsync monitor
`default_nettype none

module frame_sync_monitor import cam_diag_pkg::*; (
    input  logic         cam1_pclk,
    input  logic         rst_n,
    input  logic         field_toggle,
    input  logic         vsync_toggle,
    output sync_counts_t counts,
    output logic         field_parity
);

    logic [vsync_sync_stages-1:0] vsync_sync;
    logic                         field_d;
    logic                         field_event;
    logic                         vsync_event;
    logic [cnt16_w-1:0]           in_next;
    logic [cnt16_w-1:0]           out_next;

    // ******************************************************************
    // Event detection.
    // ******************************************************************
    assign field_event = field_toggle ^ field_d;
    assign vsync_event = vsync_sync[vsync_sync_stages-1] ^ vsync_sync[vsync_sync_stages-2];

    assign field_parity = field_d;

    assign in_next  = counts.in_sof_cnt + cnt16_w'(field_event);
    assign out_next = counts.out_vsync_cnt + cnt16_w'(vsync_event);

    // ******************************************************************
    // Counters and the frame-miss latch.
    // ******************************************************************
    always_ff @(posedge cam1_pclk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_sync <= '0;
            field_d    <= 1'b0;
            counts     <= '0;
        end else begin
            // The toggle comes from the HDMI clock domain.
            vsync_sync <= {vsync_sync[vsync_sync_stages-2:0], vsync_toggle};
            field_d    <= field_toggle;

            counts.in_sof_cnt    <= in_next;
            counts.out_vsync_cnt <= out_next;

            // Compare the updated counts so that the vsync which balances
            // them also clears the flag.
            if (in_next != out_next) begin
                counts.frame_miss <= 1'b1;
            end else if (vsync_event) begin
                counts.frame_miss <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2c_frame_logger.sv
// I2C write frame logger
`default_nettype none

module i2c_frame_logger import cam_diag_pkg::*; (
    input  logic         cam1_pclk,
    input  logic         rst_n,
    input  logic         new_sample,
    input  diag_sample_t sample,
    input  logic         sda_in,
    output logic         scl,
    output logic         sda_drive_low,
    output logic         busy
);

    logic [1:0]            state;
    logic [i2c_half_w-1:0] half_cnt;
    logic                  half_tick;
    logic                  half_first;
    logic                  high_half;   // SCL is high in this half period.
    logic [3:0]            bit_cnt;     // Bit 8 is the ACK slot.
    logic [1:0]            byte_cnt;
    logic [31:0]           frame_sr;
    logic                  shift_en;

    assign half_tick  = (half_cnt == i2c_half_w'(i2c_clks_per_half - 1));
    assign half_first = (half_cnt == '0);

    assign shift_en = (state == st_data) && high_half && half_tick && (bit_cnt != 4'd8);

    // ******************************************************************
    // Frame shifter. Address, page, value high byte, value low byte.
    // ******************************************************************
    always_ff @(posedge cam1_pclk) begin
        if ((state == st_idle) && new_sample) begin
            frame_sr <= {logger_i2c_addr, 1'b0, sample.page, sample.value.raw};
        end else if (shift_en) begin
            frame_sr <= {frame_sr[30:0], 1'b0};
        end
    end

    // ******************************************************************
    // Bus sequencer. SDA only moves on the first cycle of a low half.
    // ******************************************************************
    always_ff @(posedge cam1_pclk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            half_cnt      <= '0;
            high_half     <= 1'b0;
            bit_cnt       <= '0;
            byte_cnt      <= '0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            busy          <= 1'b0;
        end else begin
            if ((state == st_idle) || half_tick) begin
                half_cnt <= '0;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end

            case (state)
                st_idle: begin
                    if (new_sample) begin
                        state         <= st_start;
                        busy          <= 1'b1;
                        sda_drive_low <= 1'b1;   // Start condition, SCL still high.
                        high_half     <= 1'b1;
                    end
                end
                st_start: begin
                    if (half_tick) begin
                        if (high_half) begin
                            scl       <= 1'b0;
                            high_half <= 1'b0;
                        end else begin
                            state    <= st_data;
                            bit_cnt  <= '0;
                            byte_cnt <= '0;
                        end
                    end
                end
                st_data: begin
                    if (!high_half && half_first) begin
                        sda_drive_low <= (bit_cnt == 4'd8) ? 1'b0 : ~frame_sr[31];
                    end
                    if (half_tick) begin
                        scl       <= ~high_half;
                        high_half <= ~high_half;
                        if (high_half && (bit_cnt == 4'd8)) begin
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (byte_cnt == 2'd3) begin
                                state <= st_stop;
                            end
                        end else if (high_half) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (!high_half && half_first) begin
                        sda_drive_low <= 1'b1;
                    end
                    if (half_tick) begin
                        if (!high_half) begin
                            scl       <= 1'b1;
                            high_half <= 1'b1;
                        end else if (bit_cnt == 4'd0) begin
                            sda_drive_low <= 1'b0;   // Stop condition.
                            bit_cnt       <= 4'd1;
                        end else begin
                            state     <= st_idle;
                            busy      <= 1'b0;
                            bit_cnt   <= '0;
                            high_half <= 1'b0;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/reset_sync.sv
// Camera reset release
`default_nettype none

module reset_sync import cam_diag_pkg::*; (
    input  logic cam1_pclk,
    input  logic cam_resetn,
    output logic rst_n
);

    logic [reset_cnt_w-1:0] rst_cnt;

    // The count freezes once the release has happened.
    always_ff @(posedge cam1_pclk or negedge cam_resetn) begin
        if (!cam_resetn) begin
            rst_cnt <= '0;
            rst_n   <= 1'b0;
        end else if (!rst_n) begin
            rst_cnt <= rst_cnt + 1'b1;
            rst_n   <= (rst_cnt == reset_cnt_w'(reset_release_clks - 1));
        end
    end

endmodule

`default_nettype wire

// File: src.f
hdl/cam_diag_pkg.sv
hdl/reset_sync.sv
hdl/field_line_counter.sv
hdl/frame_sync_monitor.sv
hdl/diag_pager.sv
hdl/i2c_frame_logger.sv
hdl/cam_diag_top.sv
tests/cam_diag_chk.sv
tests/cam_diag_tb.sv

// File: tests/cam_diag_chk.sv
// Bus and handshake assertions
`default_nettype none

module cam_diag_chk (
    input logic cam1_pclk,
    input logic rst_n,
    input logic new_sample,
    input logic busy,
    input logic scl,
    input logic sda_drive_low
);

    timeunit 1ns;
    timeprecision 1ps;

    logic reset_seen;   // Reset was already low at the previous edge.
    int   fail_count = 0;

    always_ff @(posedge cam1_pclk) begin
        reset_seen <= !rst_n;
    end

    a_busy_after_offer: assert property (@(posedge cam1_pclk) disable iff (!rst_n)
        $rose(busy) |-> $past(new_sample))
        else begin
            $error("busy rose without a new_sample in the cycle before");
            fail_count++;
        end

    a_offer_when_idle: assert property (@(posedge cam1_pclk) disable iff (!rst_n)
        new_sample |-> !busy)
        else begin
            $error("new_sample was raised while the logger was busy");
            fail_count++;
        end

    // With SCL high, SDA may only be pulled low at a start.
    a_sda_rise_is_start: assert property (@(posedge cam1_pclk) disable iff (!rst_n)
        (scl && $past(scl) && $rose(sda_drive_low)) |-> $rose(busy))
        else begin
            $error("SDA was pulled low while SCL was high outside a start condition");
            fail_count++;
        end

    // A release with SCL high is a stop, which only happens inside a frame.
    a_sda_fall_is_stop: assert property (@(posedge cam1_pclk) disable iff (!rst_n)
        (scl && $past(scl) && $fell(sda_drive_low)) |-> busy)
        else begin
            $error("SDA was released while SCL was high outside a frame");
            fail_count++;
        end

    a_scl_high_in_reset: assert property (@(posedge cam1_pclk)
        (!rst_n && reset_seen) |-> scl)
        else begin
            $error("SCL was low while reset was held");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tests/cam_diag_tb.sv
// Camera diagnostic testbench
`default_nettype none

module cam_diag_tb import cam_diag_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period     = 20;
    localparam int test_intervals = 3 + 8 + 10 + 16 + 12;   // Pager intervals per test.
    localparam int watchdog_ns    = (test_intervals + 5) * pager_interval_clks * clk_period;

    logic cam1_pclk;
    logic cam_resetn;
    logic line_valid;
    logic field_toggle;
    logic vsync_toggle;
    logic sda_in;
    logic scl;
    logic sda_drive_low;

    int           errors = 0;
    int           checks = 0;
    logic [15:0]  lfsr = 16'd12052;
    logic [15:0]  exp_k = '0;   // Field starts driven so far.
    logic [15:0]  exp_m = '0;   // Vsync toggles driven so far.
    diag_sample_t rx_sample;
    time          rx_start = 0;
    int           rx_count = 0;

    cam_diag_top i_dut (
        .cam1_pclk     (cam1_pclk),
        .cam_resetn    (cam_resetn),
        .line_valid    (line_valid),
        .field_toggle  (field_toggle),
        .vsync_toggle  (vsync_toggle),
        .sda_in        (sda_in),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    bind cam_diag_top cam_diag_chk i_chk (
        .cam1_pclk     (cam1_pclk),
        .rst_n         (rst_n),
        .new_sample    (new_sample),
        .busy          (busy),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    initial begin
        cam1_pclk = 1'b0;
        forever #(clk_period / 2) cam1_pclk = ~cam1_pclk;
    end

    // ******************************************************************
    // Compare tasks and stimulus helpers.
    // ******************************************************************
    task automatic check_sample(input string name, input diag_sample_t exp,
                                input diag_sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected page %0d value %h, actual page %0d value %h",
                     name, exp.page, exp.value.raw, act.page, act.value.raw);
        end
    endtask

    task automatic check_flags(input string name, input status_flags_t exp,
                               input status_flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected parity/equal/miss %b%b%b, actual %b%b%b (raw %h)",
                     name, exp.field_parity, exp.counts_equal, exp.frame_miss,
                     act.field_parity, act.counts_equal, act.frame_miss, act);
        end
    endtask

    task automatic check_count(input string name, input logic [cnt16_w-1:0] exp,
                               input logic [cnt16_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("%s", what);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1.
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge cam1_pclk);
        #2;
    endtask

    task automatic toggle_field();
        field_toggle = ~field_toggle;
        exp_k        = exp_k + 16'd1;
        step(6);
    endtask

    task automatic toggle_vsync();
        vsync_toggle = ~vsync_toggle;
        exp_m        = exp_m + 16'd1;
        step(6);   // Covers the synchronizer latency.
    endtask

    // ******************************************************************
    // I2C decoder. Samples the bus on rising SCL and hands out frames.
    // ******************************************************************
    initial begin : i2c_decoder
        logic [31:0] bits;
        logic [7:0]  last_page;
        time         t_start;
        last_page = 8'd4;   // So the first frame is expected to carry page 0.
        forever begin
            @(posedge sda_drive_low);
            if (scl) begin
                t_start = $time;
                bits    = '0;
                for (int i = 0; i < 36; i++) begin
                    @(posedge scl);
                    if (i % 9 == 8) begin
                        check_condition(!sda_drive_low, "SDA was held low in an ACK slot");
                    end else begin
                        bits = {bits[30:0], ~sda_drive_low};
                    end
                end
                @(negedge sda_drive_low);
                check_condition(scl, "The frame did not end with a stop condition");
                check_count("i2c_address", 16'h00BA, {8'h00, bits[31:24]});
                check_count("page_sequence",
                            (last_page == 8'd4) ? 16'd0 : {8'h00, last_page + 8'd1},
                            {8'h00, bits[23:16]});
                last_page = bits[23:16];
                rx_sample = bits[23:0];
                rx_start  = t_start;
                rx_count++;
            end
        end
    end

    // Returns the first frame that starts after the call.
    task automatic next_frame(output diag_sample_t s);
        time t_call;
        int  n;
        t_call = $time;
        n      = rx_count;
        wait ((rx_count != n) && (rx_start >= t_call));
        s = rx_sample;
    endtask

    task automatic capture_page(input logic [7:0] page, output diag_sample_t s);
        diag_sample_t frame;
        bit           found;
        found = 1'b0;
        s     = '0;
        for (int i = 0; (i < num_pages + 1) && !found; i++) begin
            next_frame(frame);
            if (frame.page == page) begin
                found = 1'b1;
                s     = frame;
            end
        end
        check_condition(found, $sformatf("Page %0d did not arrive within %0d frames",
                                         page, num_pages + 1));
    endtask

    // ******************************************************************
    // Tests.
    // ******************************************************************
    task automatic test_reset();
        diag_sample_t exp;
        diag_sample_t act;
        step(8);
        check_condition(scl && !sda_drive_low, "The I2C bus was not idle while reset was held");
        cam_resetn = 1'b1;
        step(reset_release_clks + 1);
        check_condition(scl && !sda_drive_low, "The I2C bus was not idle after reset");
        exp = '0;   // Page 0, no field has ended yet.
        next_frame(act);
        check_sample("reset_first_frame", exp, act);
    endtask

    task automatic test_lines();
        diag_sample_t exp;
        diag_sample_t act;
        int           n;
        take_bits(6, n);
        if (n == 0) begin
            n = 1;
        end
        for (int i = 0; i < n; i++) begin
            line_valid = 1'b1;
            step(2);
            line_valid = 1'b0;
            step(2);
        end
        toggle_field();
        exp.page      = 8'd0;
        exp.value.raw = 16'(n);
        capture_page(8'd0, act);
        check_sample("lines_per_field", exp, act);
    endtask

    task automatic test_sync_counts();
        diag_sample_t act;
        int           k;
        int           m;
        take_bits(3, k);
        take_bits(3, m);
        for (int i = 0; i < 8; i++) begin
            if (i <= k) toggle_field();
            if (i <= m) toggle_vsync();
        end
        capture_page(8'd1, act);
        check_count("field_starts", exp_k, act.value.raw);
        capture_page(8'd2, act);
        check_count("vsync_count", exp_m, act.value.raw);
        capture_page(8'd3, act);
        check_count("count_delta", exp_k - exp_m, act.value.raw);
    endtask

    task automatic test_flags();
        status_flags_t exp;
        diag_sample_t  act;
        if (exp_k == exp_m) toggle_field();
        exp              = '0;
        exp.field_parity = field_toggle;
        exp.frame_miss   = 1'b1;
        capture_page(8'd4, act);
        check_flags("flags_unequal", exp, act.value.flags);
        // Field count leads, so the vsync that balances it comes last.
        while (exp_k <= exp_m) toggle_field();
        while (exp_m < exp_k) toggle_vsync();
        exp              = '0;
        exp.field_parity = field_toggle;
        exp.counts_equal = 1'b1;
        capture_page(8'd4, act);
        check_flags("flags_balanced", exp, act.value.flags);
    endtask

    task automatic test_page_order();
        diag_sample_t act;
        capture_page(8'd0, act);
        for (int p = 1; p <= num_pages; p++) begin
            next_frame(act);
            check_count("page_order", 16'(p % num_pages), {8'h00, act.page});
        end
    endtask

    initial begin
        cam_resetn   = 1'b0;
        line_valid   = 1'b0;
        field_toggle = 1'b0;
        vsync_toggle = 1'b0;
        sda_in       = 1'b1;   // No target on the bus, the pull-up wins.
        test_reset();
        test_lines();
        test_sync_counts();
        test_flags();
        test_page_order();
        errors += i_dut.i_chk.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
